/* build.f */
+incdir+common
common/motion_pkg.sv
hdl/spi_word_rx.sv
motion/command_decoder.sv
motion/move_queue.sv
motion/dda_stepper.sv
hdl/quad_decoder.sv
hdl/motion_top.sv
dv/motion_tb.sv

/* common/motion_config.svh */
`ifndef MOTION_CONFIG_SVH
`define MOTION_CONFIG_SVH

// SPI word and field widths
`define WORD_W 64
`define HEADER_W 8
`define DURATION_W 32
`define RATE_W 40
`define ACCUM_W 48
`define DIVISOR_W 8
`define ENC_W 48

// Command codes, carried in word bits 63:56
`define CMD_MOTOR_ENABLE 8'h01
`define CMD_CLK_DIVISOR 8'h02
`define CMD_API_VERSION 8'h03
`define CMD_COORDINATED_STEP 8'h04

// Version bytes returned after API_VERSION
`define VERSION_MAJOR 8'd0
`define VERSION_MINOR 8'd2
`define VERSION_PATCH 8'd1

// CLK cycles per DDA tick out of reset
`define DEFAULT_CLK_DIVISOR 8'd40

// Removed from the DDA accumulator on every step, 2**32
`define DDA_THRESHOLD 48'sd4294967296

// Pending moves held between decoder and stepper
`define MOVE_QUEUE_DEPTH 4

`endif

/* common/motion_pkg.sv */
package motion_pkg;

  `include "motion_config.svh"

  // Raw SPI word, MSB first on the wire
  typedef logic [`WORD_W-1:0] word_t;

  // Command code from the top byte
  typedef logic [`HEADER_W-1:0] header_t;

  // Move length in DDA ticks
  typedef logic [`DURATION_W-1:0] duration_t;

  // Signed increment and increment-increment
  typedef logic signed [`RATE_W-1:0] rate_t;

  // Signed substep accumulator
  typedef logic signed [`ACCUM_W-1:0] accum_t;

  // CLK cycles per DDA tick
  typedef logic [`DIVISOR_W-1:0] divisor_t;

  // Signed shaft position
  typedef logic signed [`ENC_W-1:0] enc_count_t;

  // Which word of a command is expected next
  typedef enum logic [1:0] {
    DEC_HEADER,
    DEC_DURATION,
    DEC_INCREMENT,
    DEC_INCR_INCR
  } decode_state_t;

endpackage

/* dv/motion_tb.sv */
`include "motion_config.svh"

module motion_tb
  import motion_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  // SCK half period in CLK cycles, CLK/8
  localparam int SCK_HALF = 4;
  localparam int XFER_CYCLES = 2 * SCK_HALF * (`WORD_W + 2) + 16;
  localparam int N_XFERS = 36;
  localparam int DIVISOR_TEST = 4;
  localparam int MIN_DUR = 16;
  localparam int MAX_DUR = MIN_DUR + 31;
  localparam int N_MOVES = `MOVE_QUEUE_DEPTH + 2;
  localparam int ENC_MAX = 200;
  localparam int ENC_HOLD = 4;
  localparam int ENC_ROUNDS = 2;
  // Twice the planned transfers, move ticks and encoder steps
  localparam int TIMEOUT_CYCLES = 2 * (N_XFERS * XFER_CYCLES
    + N_MOVES * MAX_DUR * DIVISOR_TEST + ENC_ROUNDS * ENC_MAX * ENC_HOLD + 64);

  logic CLK = 1'b0;
  logic rst;
  logic sck;
  logic cs_n;
  logic copi;
  logic cipo;
  logic enc_a;
  logic enc_b;
  logic step;
  logic dir;
  logic motor_enable;
  logic led;

  int seed = 32'he2b9;
  int cycle_count = 0;
  int step_count = 0;
  int words_sent = 0;
  int enc_phase = 0;
  enc_count_t enc_total = '0;
  // Reference DDA accumulator, spans moves like the stepper
  accum_t model_acc = '0;

  motion_top UUT (
    .CLK(CLK), .rst(rst), .sck(sck), .cs_n(cs_n), .copi(copi), .cipo(cipo),
    .enc_a(enc_a), .enc_b(enc_b), .step(step), .dir(dir),
    .motor_enable(motor_enable), .led(led)
  );

  always #50 CLK = ~CLK;

  // Step pulses are one CLK wide
  always @(negedge CLK) begin
    if (step) step_count = step_count + 1;
  end

  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout, the run did not finish within %0d CLK cycles", TIMEOUT_CYCLES);
      stop_run();
    end
  end

  task stop_run();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_count(input string name, input enc_count_t exp, input enc_count_t act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_int(input string name, input int exp, input int act);
    if (act !== exp) begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  // One mode 0 word, MSB first, reply sampled before each rising SCK
  task automatic spi_xfer(input word_t tx, output word_t rx);
    int wait_cnt;
    @(negedge CLK);
    cs_n = 1'b0;
    repeat (SCK_HALF) @(negedge CLK);
    for (int i = `WORD_W - 1; i >= 0; i--) begin
      copi = tx[i];
      repeat (SCK_HALF) @(negedge CLK);
      rx[i] = cipo;
      sck = 1'b1;
      if (i > 0) begin
        repeat (SCK_HALF) @(negedge CLK);
      end else begin
        // Last bit held high until the word is taken
        wait_cnt = 0;
        while (!UUT.word_valid) begin
          @(negedge CLK);
          wait_cnt++;
          if (wait_cnt > 2 * SCK_HALF) begin
            $display("No word_valid after the last SCK edge");
            stop_run();
          end
        end
      end
      sck = 1'b0;
    end
    repeat (SCK_HALF) @(negedge CLK);
    cs_n = 1'b1;
    repeat (SCK_HALF) @(negedge CLK);
    words_sent++;
  endtask

  function automatic logic [1:0] phase_to_ab(input int phase);
    case (phase)
      0: return 2'b00;
      1: return 2'b01;
      2: return 2'b11;
      default: return 2'b10;
    endcase
  endfunction

  // Positive n walks 00 01 11 10, negative walks back
  task automatic enc_steps(input int n);
    int count;
    count = (n < 0) ? -n : n;
    repeat (count) begin
      @(negedge CLK);
      enc_phase = (n > 0) ? (enc_phase + 1) % 4 : (enc_phase + 3) % 4;
      {enc_a, enc_b} = phase_to_ab(enc_phase);
      repeat (ENC_HOLD - 1) @(negedge CLK);
    end
    enc_total = enc_total + enc_count_t'(n);
  endtask

  // DDA rule per tick, rate then accumulate then step on positive
  task automatic model_move(input duration_t dur, input rate_t inc, input rate_t incinc,
                            output int steps);
    rate_t r;
    steps = 0;
    r = '0;
    for (int unsigned t = 0; t < dur; t++) begin
      r = (t == 0) ? inc : r + incinc;
      model_acc = model_acc + accum_t'(r);
      if (model_acc > 0) begin
        steps++;
        model_acc = model_acc - `DDA_THRESHOLD;
      end
    end
  endtask

  // Mostly forward rates, up to half a step per tick
  task automatic random_move(output logic d, output duration_t dur, output rate_t inc,
                             output rate_t incinc);
    int r;
    r = $random(seed);
    d = r[0];
    dur = duration_t'(MIN_DUR + ($random(seed) & 31));
    inc = rate_t'($random(seed) & 32'h7fff_ffff);
    incinc = rate_t'($random(seed) >>> 14);
  endtask

  task automatic send_move(input logic d, input duration_t dur, input rate_t inc,
                           input rate_t incinc);
    word_t reply;
    spi_xfer({`CMD_COORDINATED_STEP, 55'd0, d}, reply);
    spi_xfer({32'd0, dur}, reply);
    spi_xfer({24'd0, inc}, reply);
    spi_xfer({24'd0, incinc}, reply);
  endtask

  // Start of the first move, then queue drained and stepper idle
  task automatic wait_moves_done();
    int guard;
    guard = 0;
    while (!UUT.u_stepper.busy) begin
      @(negedge CLK);
      guard++;
      if (guard > 8 * SCK_HALF) begin
        $display("Stepper never started a move");
        stop_run();
      end
    end
    while (UUT.u_stepper.busy || UUT.move_valid) @(negedge CLK);
    // Last step pulse lands with busy falling
    @(negedge CLK);
  endtask

  task automatic test_reset_version();
    word_t reply;
    check_int("step", 0, step);
    check_int("motor_enable", 0, motor_enable);
    check_int("led", 0, led);
    spi_xfer({`CMD_API_VERSION, 56'd0}, reply);
    spi_xfer('0, reply);
    check_word("reply_word", {40'd0, `VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH}, reply);
  endtask

  task automatic test_encoder();
    word_t reply;
    int n;
    for (int round = 0; round < ENC_ROUNDS; round++) begin
      n = $random(seed) % ENC_MAX;
      enc_steps(n);
      spi_xfer('0, reply);
      check_count("encoder count", enc_total, enc_count_t'(reply[`ENC_W-1:0]));
    end
    // Both lines flip together
    @(negedge CLK);
    enc_phase = (enc_phase + 2) % 4;
    {enc_a, enc_b} = phase_to_ab(enc_phase);
    repeat (ENC_HOLD) @(negedge CLK);
    spi_xfer('0, reply);
    check_int("encoder fault", 1, int'(reply[62]));
    check_count("encoder count", enc_total, enc_count_t'(reply[`ENC_W-1:0]));
  endtask

  task automatic test_settings();
    word_t reply;
    spi_xfer({`CMD_MOTOR_ENABLE, 55'd0, 1'b1}, reply);
    check_int("motor_enable", 1, motor_enable);
    check_int("led", words_sent % 2, led);
    spi_xfer({`CMD_MOTOR_ENABLE, 56'd0}, reply);
    check_int("motor_enable", 0, motor_enable);
    check_int("led", words_sent % 2, led);
  endtask

  task automatic test_single_move();
    word_t reply;
    logic d;
    duration_t dur;
    rate_t inc;
    rate_t incinc;
    int expected;
    spi_xfer({`CMD_CLK_DIVISOR, 48'd0, 8'(DIVISOR_TEST)}, reply);
    spi_xfer({`CMD_MOTOR_ENABLE, 55'd0, 1'b1}, reply);
    random_move(d, dur, inc, incinc);
    model_move(dur, inc, incinc, expected);
    step_count = 0;
    send_move(d, dur, inc, incinc);
    wait_moves_done();
    check_int("dir", int'(d), int'(dir));
    check_int("step count", expected, step_count);
  endtask

  task automatic test_queue_overflow();
    word_t reply;
    logic d;
    logic last_dir;
    duration_t dur;
    rate_t inc;
    rate_t incinc;
    int steps;
    int expected;
    expected = 0;
    last_dir = 1'b0;
    spi_xfer({`CMD_MOTOR_ENABLE, 56'd0}, reply);
    for (int i = 0; i <= `MOVE_QUEUE_DEPTH; i++) begin
      random_move(d, dur, inc, incinc);
      send_move(d, dur, inc, incinc);
      // The extra move finds the queue full
      if (i < `MOVE_QUEUE_DEPTH) begin
        model_move(dur, inc, incinc, steps);
        expected += steps;
        last_dir = d;
      end
    end
    spi_xfer('0, reply);
    check_int("overflow flag", 1, int'(reply[63]));
    step_count = 0;
    spi_xfer({`CMD_MOTOR_ENABLE, 55'd0, 1'b1}, reply);
    wait_moves_done();
    check_int("dir", int'(last_dir), int'(dir));
    check_int("step count", expected, step_count);
  endtask

  initial begin
    rst = 1'b1;
    sck = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    enc_a = 1'b0;
    enc_b = 1'b0;
    repeat (4) @(negedge CLK);
    rst = 1'b0;
    @(negedge CLK);
    test_reset_version();
    test_encoder();
    test_settings();
    test_single_move();
    test_queue_overflow();
    $display("TEST OK");
    $finish;
  end

endmodule

/* hdl/motion_top.sv */
module motion_top
  import motion_pkg::*;
(
  input  logic CLK,
  input  logic rst,
  input  logic sck,
  input  logic cs_n,
  input  logic copi,
  output logic cipo,
  input  logic enc_a,
  input  logic enc_b,
  output logic step,
  output logic dir,
  output logic motor_enable,
  output logic led
);

  // SPI word link
  word_t word_data;
  word_t reply_word;
  logic word_valid;

  // Decoder to queue
  logic push_valid;
  logic push_ready;
  logic push_dir;
  duration_t push_duration;
  rate_t push_increment;
  rate_t push_incr_incr;

  // Queue to stepper
  logic move_valid;
  logic move_ready;
  logic move_dir;
  duration_t move_duration;
  rate_t move_increment;
  rate_t move_incr_incr;

  divisor_t clk_divisor;
  enc_count_t enc_count;
  logic enc_fault;

  spi_word_rx u_spi (
    .CLK(CLK), .rst(rst), .sck(sck), .cs_n(cs_n), .copi(copi), .cipo(cipo),
    .reply_word(reply_word), .word_valid(word_valid), .word_data(word_data)
  );

  command_decoder u_decoder (
    .CLK(CLK), .rst(rst), .word_valid(word_valid), .word_data(word_data),
    .reply_word(reply_word), .motor_enable(motor_enable), .clk_divisor(clk_divisor),
    .push_valid(push_valid), .push_ready(push_ready), .push_dir(push_dir),
    .push_duration(push_duration), .push_increment(push_increment),
    .push_incr_incr(push_incr_incr), .enc_count(enc_count), .enc_fault(enc_fault),
    .led(led)
  );

  move_queue u_queue (
    .CLK(CLK), .rst(rst), .push_valid(push_valid), .push_ready(push_ready),
    .push_dir(push_dir), .push_duration(push_duration), .push_increment(push_increment),
    .push_incr_incr(push_incr_incr), .move_valid(move_valid), .move_ready(move_ready),
    .move_dir(move_dir), .move_duration(move_duration), .move_increment(move_increment),
    .move_incr_incr(move_incr_incr)
  );

  // busy stays inside the stepper, watched from the testbench
  dda_stepper u_stepper (
    .CLK(CLK), .rst(rst), .motor_enable(motor_enable), .clk_divisor(clk_divisor),
    .move_valid(move_valid), .move_ready(move_ready), .move_dir(move_dir),
    .move_duration(move_duration), .move_increment(move_increment),
    .move_incr_incr(move_incr_incr), .step(step), .dir(dir), .busy()
  );

  quad_decoder u_encoder (
    .CLK(CLK), .rst(rst), .enc_a(enc_a), .enc_b(enc_b),
    .count(enc_count), .fault(enc_fault)
  );

endmodule

/* hdl/quad_decoder.sv */
module quad_decoder
  import motion_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  logic       enc_a,
  input  logic       enc_b,
  output enc_count_t count,
  output logic       fault
);

  // Pairs are {a, b}
  logic [1:0] ab_meta;
  logic [1:0] ab_sync;
  logic [1:0] ab_prev;

  // Synchronizers run through reset
  always_ff @(posedge CLK) begin
    ab_meta <= {enc_a, enc_b};
    ab_sync <= ab_meta;
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      // Track the pins so release gives no false edge
      ab_prev <= ab_sync;
      count <= '0;
      fault <= 1'b0;
    end else begin
      ab_prev <= ab_sync;
      case ({ab_prev, ab_sync})
        // 00 -> 01 -> 11 -> 10 forward
        4'b0001, 4'b0111, 4'b1110, 4'b1000: count <= count + 1'b1;
        // Reverse order
        4'b0010, 4'b1011, 4'b1101, 4'b0100: count <= count - 1'b1;
        // Both bits moved, position lost
        4'b0011, 4'b1100, 4'b0110, 4'b1001: fault <= 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* hdl/spi_word_rx.sv */
module spi_word_rx
  import motion_pkg::*;
(
  input  logic  CLK,
  input  logic  rst,
  input  logic  sck,
  input  logic  cs_n,
  input  logic  copi,
  output logic  cipo,
  input  word_t reply_word,
  output logic  word_valid,
  output word_t word_data
);

  localparam int WORD_BITS = $bits(word_t);
  localparam int CNT_W = $clog2(WORD_BITS);

  // Two flops to sync, third one for edge detect
  logic [2:0] sck_sync;
  logic [2:0] cs_sync;
  logic [1:0] copi_sync;

  logic sck_rise;
  logic sck_fall;
  logic cs_fall;
  logic cs_active;

  logic [CNT_W-1:0] bit_cnt;
  word_t rx_shift;
  word_t tx_shift;

  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];
  assign cs_fall = ~cs_sync[1] & cs_sync[2];
  assign cs_active = ~cs_sync[1];

  // MSB of the reply goes out first
  assign cipo = tx_shift[WORD_BITS-1];

  always_ff @(posedge CLK) begin
    if (rst) begin
      sck_sync <= '0;
      cs_sync <= '1;
      bit_cnt <= '0;
      word_valid <= 1'b0;
    end else begin
      sck_sync <= {sck_sync[1:0], sck};
      cs_sync <= {cs_sync[1:0], cs_n};
      word_valid <= 1'b0;
      if (!cs_active) begin
        // Deselect drops any partial word
        bit_cnt <= '0;
      end else if (sck_rise) begin
        bit_cnt <= bit_cnt + 1'b1;
        // Count wraps to zero after the last bit
        if (bit_cnt == CNT_W'(WORD_BITS - 1)) begin
          word_valid <= 1'b1;
        end
      end
    end
  end

  // Shift registers and data synchronizer
  always_ff @(posedge CLK) begin
    copi_sync <= {copi_sync[0], copi};
    if (cs_active && sck_rise) begin
      rx_shift <= {rx_shift[WORD_BITS-2:0], copi_sync[1]};
      if (bit_cnt == CNT_W'(WORD_BITS - 1)) begin
        word_data <= {rx_shift[WORD_BITS-2:0], copi_sync[1]};
      end
    end
    // Load reply at select, shift on falling SCK
    if (cs_fall) begin
      tx_shift <= reply_word;
    end else if (cs_active && sck_fall) begin
      tx_shift <= {tx_shift[WORD_BITS-2:0], 1'b0};
    end
  end

endmodule

/* motion/command_decoder.sv */
`include "motion_config.svh"

module command_decoder
  import motion_pkg::*;
(
  input  logic       CLK,
  input  logic       rst,
  input  logic       word_valid,
  input  word_t      word_data,
  output word_t      reply_word,
  output logic       motor_enable,
  output divisor_t   clk_divisor,
  output logic       push_valid,
  input  logic       push_ready,
  output logic       push_dir,
  output duration_t  push_duration,
  output rate_t      push_increment,
  output rate_t      push_incr_incr,
  input  enc_count_t enc_count,
  input  logic       enc_fault,
  output logic       led
);

  decode_state_t state;
  header_t header;

  // Sticky until reset, SPI cannot be stalled
  logic overflow;
  // Next reply carries version bytes
  logic version_reply;

  assign header = word_data[`WORD_W-1 -: `HEADER_W];

  // Reply follows live count and flags
  always_comb begin
    reply_word = '0;
    reply_word[`WORD_W-1] = overflow;
    reply_word[`WORD_W-2] = enc_fault;
    if (version_reply) begin
      reply_word[23:0] = {`VERSION_MAJOR, `VERSION_MINOR, `VERSION_PATCH};
    end else begin
      reply_word[`ENC_W-1:0] = enc_count;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= DEC_HEADER;
      motor_enable <= 1'b0;
      clk_divisor <= `DEFAULT_CLK_DIVISOR;
      push_valid <= 1'b0;
      overflow <= 1'b0;
      version_reply <= 1'b0;
      led <= 1'b0;
    end else begin
      push_valid <= 1'b0;
      // Move is lost if queue was full
      if (push_valid && !push_ready) begin
        overflow <= 1'b1;
      end
      if (word_valid) begin
        led <= ~led;
        version_reply <= 1'b0;
        case (state)
          DEC_HEADER: begin
            case (header)
              `CMD_MOTOR_ENABLE: motor_enable <= word_data[0];
              `CMD_CLK_DIVISOR: begin
                // Zero divisor would stall the tick
                if (word_data[7:0] != 8'd0) begin
                  clk_divisor <= word_data[`DIVISOR_W-1:0];
                end
              end
              `CMD_API_VERSION: version_reply <= 1'b1;
              `CMD_COORDINATED_STEP: state <= DEC_DURATION;
              default: ;
            endcase
          end
          DEC_DURATION: state <= DEC_INCREMENT;
          DEC_INCREMENT: state <= DEC_INCR_INCR;
          DEC_INCR_INCR: begin
            // Whole move collected
            push_valid <= 1'b1;
            state <= DEC_HEADER;
          end
          default: state <= DEC_HEADER;
        endcase
      end
    end
  end

  // Move fields, held until the push
  always_ff @(posedge CLK) begin
    if (word_valid) begin
      case (state)
        DEC_HEADER: begin
          if (header == `CMD_COORDINATED_STEP) begin
            push_dir <= word_data[0];
          end
        end
        DEC_DURATION: push_duration <= word_data[`DURATION_W-1:0];
        DEC_INCREMENT: push_increment <= word_data[`RATE_W-1:0];
        DEC_INCR_INCR: push_incr_incr <= word_data[`RATE_W-1:0];
        default: ;
      endcase
    end
  end

endmodule

/* motion/dda_stepper.sv */
`include "motion_config.svh"

module dda_stepper
  import motion_pkg::*;
(
  input  logic      CLK,
  input  logic      rst,
  input  logic      motor_enable,
  input  divisor_t  clk_divisor,
  input  logic      move_valid,
  output logic      move_ready,
  input  logic      move_dir,
  input  duration_t move_duration,
  input  rate_t     move_increment,
  input  rate_t     move_incr_incr,
  output logic      step,
  output logic      dir,
  output logic      busy
);

  divisor_t tick_cnt;
  duration_t ticks_left;
  logic first_tick;
  logic tick;

  // Held copy of the running move
  rate_t increment;
  rate_t incr_incr;
  rate_t rate;

  // Remainder carries over between moves
  accum_t acc;

  rate_t rate_next;
  accum_t acc_sum;

  // Pull the next move only when idle and enabled
  assign move_ready = ~busy & motor_enable;

  // Divider paused while disabled, move frozen
  assign tick = busy && motor_enable && (tick_cnt >= divisor_t'(clk_divisor - 1'b1));

  always_comb begin
    rate_next = first_tick ? increment : rate + incr_incr;
    acc_sum = acc + accum_t'(rate_next);
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      busy <= 1'b0;
      step <= 1'b0;
      dir <= 1'b0;
      acc <= '0;
      tick_cnt <= '0;
      first_tick <= 1'b0;
    end else begin
      step <= 1'b0;
      if (move_valid && move_ready) begin
        // Zero length move is consumed without running
        busy <= (move_duration != '0);
        dir <= move_dir;
        first_tick <= 1'b1;
        tick_cnt <= '0;
      end else if (tick) begin
        tick_cnt <= '0;
        first_tick <= 1'b0;
        // Crossing zero means one full step
        if (acc_sum > 0) begin
          step <= 1'b1;
          acc <= acc_sum - `DDA_THRESHOLD;
        end else begin
          acc <= acc_sum;
        end
        if (ticks_left == duration_t'(1)) begin
          busy <= 1'b0;
        end
      end else if (busy && motor_enable) begin
        tick_cnt <= tick_cnt + 1'b1;
      end
    end
  end

  // Move payload
  always_ff @(posedge CLK) begin
    if (move_valid && move_ready) begin
      ticks_left <= move_duration;
      increment <= move_increment;
      incr_incr <= move_incr_incr;
    end else if (tick) begin
      ticks_left <= ticks_left - 1'b1;
      rate <= rate_next;
    end
  end

endmodule

/* motion/move_queue.sv */
`include "motion_config.svh"

module move_queue
  import motion_pkg::*;
#(
  parameter int DEPTH = `MOVE_QUEUE_DEPTH
) (
  input  logic      CLK,
  input  logic      rst,
  input  logic      push_valid,
  output logic      push_ready,
  input  logic      push_dir,
  input  duration_t push_duration,
  input  rate_t     push_increment,
  input  rate_t     push_incr_incr,
  output logic      move_valid,
  input  logic      move_ready,
  output logic      move_dir,
  output duration_t move_duration,
  output rate_t     move_increment,
  output rate_t     move_incr_incr
);

  localparam int AW = $clog2(DEPTH);

  // Extra MSB tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] rd_ptr;

  logic      dir_mem [DEPTH];
  duration_t dur_mem [DEPTH];
  rate_t     inc_mem [DEPTH];
  rate_t     incinc_mem [DEPTH];

  logic empty;
  logic full;
  logic do_push;
  logic do_pop;

  assign empty = (wr_ptr == rd_ptr);
  assign full = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign push_ready = ~full;
  assign move_valid = ~empty;
  assign do_push = push_valid && push_ready;
  assign do_pop = move_valid && move_ready;

  // Head comes straight from storage
  assign move_dir = dir_mem[rd_ptr[AW-1:0]];
  assign move_duration = dur_mem[rd_ptr[AW-1:0]];
  assign move_increment = inc_mem[rd_ptr[AW-1:0]];
  assign move_incr_incr = incinc_mem[rd_ptr[AW-1:0]];

  always_ff @(posedge CLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (do_push) begin
      dir_mem[wr_ptr[AW-1:0]] <= push_dir;
      dur_mem[wr_ptr[AW-1:0]] <= push_duration;
      inc_mem[wr_ptr[AW-1:0]] <= push_increment;
      incinc_mem[wr_ptr[AW-1:0]] <= push_incr_incr;
    end
  end

endmodule

/* run_sim.sh */
#!/bin/bash
# Build the motion core testbench with Verilator and run it into sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary -Wno-fatal --top-module motion_tb -f build.f -Mdir obj_dir -o motion_sim \
  && ./obj_dir/motion_sim > sim.log 2>&1 \
  || echo "Build or simulation stopped with an error"

# The log decides the result
grep -qs "^TEST OK$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
